//--- design/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int WORD_W     = 32;
    localparam int SETS       = 8;
    localparam int IDX_W      = 3;
    localparam int TAG_W      = 26;
    localparam int BLK_WORDS  = 2;
    localparam int BYTE_OFF_W = 2;

    // data word or byte address
    typedef logic [WORD_W-1:0] word_t;

    // line tag, upper address bits
    typedef logic [TAG_W-1:0] tag_t;

    // set index
    typedef logic [IDX_W-1:0] idx_t;

    // way select, two ways
    typedef logic way_t;

    // controller states
    // TAG serves hits and starts misses
    // WB1/WB2 write back the victim, AL1/AL2 refill the block
    // HALT walks the sets for the flush, HALTWB1/HALTWB2 write back one way
    typedef enum logic [3:0] {
        TAG     = 4'd0,
        WB1     = 4'd1,
        WB2     = 4'd2,
        AL1     = 4'd3,
        AL2     = 4'd4,
        HALT    = 4'd5,
        HALTWB1 = 4'd6,
        HALTWB2 = 4'd7,
        FLUSHED = 4'd8
    } ctrl_state_t;

endpackage

//--- design/dcache_tag_match.sv
`timescale 1ns/100ps

module dcache_tag_match
    import dcache_pkg::*;
(
    input  word_t req_addr,
    input  tag_t  tag0,
    input  tag_t  tag1,
    input  logic  valid0,
    input  logic  valid1,
    input  logic  dirty0,
    input  logic  dirty1,
    input  logic  lru,
    output idx_t  req_idx,
    output logic  req_blkoff,
    output logic  hit,
    output way_t  hit_way,
    output way_t  victim_way,
    output logic  victim_dirty,
    output tag_t  victim_tag
);

    tag_t req_tag;
    logic hit0;
    logic hit1;

    // address layout: tag | index | word | byte
    assign req_tag    = req_addr[WORD_W-1 -: TAG_W];
    assign req_idx    = req_addr[BYTE_OFF_W+1 +: IDX_W];
    assign req_blkoff = req_addr[BYTE_OFF_W];

    // compare against both ways, only valid lines count
    assign hit0 = valid0 && (tag0 == req_tag);
    assign hit1 = valid1 && (tag1 == req_tag);

    assign hit     = hit0 || hit1;
    assign hit_way = hit1;

    // lru names the way to replace
    assign victim_way = lru;

    always_comb begin
        if (victim_way) begin
            victim_dirty = dirty1;
            victim_tag   = tag1;
        end else begin
            victim_dirty = dirty0;
            victim_tag   = tag0;
        end
    end

endmodule

//--- design/dcache_controller.sv
`timescale 1ns/100ps

module dcache_controller
    import dcache_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  halt,
    input  logic  dmemREN,
    input  logic  dmemWEN,
    input  word_t dmemaddr,
    input  idx_t  req_idx,
    input  logic  req_blkoff,
    input  logic  hit,
    input  way_t  hit_way,
    input  way_t  victim_way,
    input  logic  victim_dirty,
    input  tag_t  victim_tag,
    input  logic  dirty0,
    input  logic  dirty1,
    input  tag_t  tag0,
    input  tag_t  tag1,
    input  logic  dwait,
    output logic  dhit,
    output logic  flushed,
    output logic  dREN,
    output logic  dWEN,
    output word_t daddr,
    output idx_t  set_idx,
    output way_t  rd_way,
    output logic  rd_word,
    output logic  fill_we,
    output way_t  fill_way,
    output logic  fill_word,
    output tag_t  fill_tag,
    output logic  cpu_we,
    output way_t  cpu_way,
    output logic  touch,
    output way_t  touch_way,
    output logic  clean_we,
    output way_t  clean_way,
    output logic  clear_set
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    idx_t        flush_idx;
    idx_t        next_flush_idx;
    logic        req;
    logic        flushing;
    way_t        flush_way;
    tag_t        flush_tag;
    tag_t        addr_tag;
    logic        addr_word;

    assign req = dmemREN || dmemWEN;

    // the flush walk owns the set index
    assign flushing = (state == HALT) || (state == HALTWB1) || (state == HALTWB2);
    assign set_idx  = flushing ? flush_idx : req_idx;

    // way 0 is written back first when both are dirty
    assign flush_way = dirty0 ? 1'b0 : 1'b1;
    assign flush_tag = flush_way ? tag1 : tag0;

    // refill goes into the victim under the request tag
    assign fill_tag  = dmemaddr[WORD_W-1 -: TAG_W];
    assign fill_way  = victim_way;
    assign cpu_way   = hit_way;
    assign touch_way = hit_way;
    assign clean_way = flush_way;

    // block-aligned memory address
    assign daddr = {addr_tag, set_idx, addr_word, {BYTE_OFF_W{1'b0}}};

    assign flushed = (state == FLUSHED) && halt;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= TAG;
            flush_idx <= '0;
        end else begin
            state     <= next_state;
            flush_idx <= next_flush_idx;
        end
    end

    always_comb begin
        next_state     = state;
        next_flush_idx = flush_idx;
        dhit           = 1'b0;
        dREN           = 1'b0;
        dWEN           = 1'b0;
        rd_way         = victim_way;
        rd_word        = 1'b0;
        addr_tag       = fill_tag;
        addr_word      = 1'b0;
        fill_we        = 1'b0;
        fill_word      = 1'b0;
        cpu_we         = 1'b0;
        touch          = 1'b0;
        clean_we       = 1'b0;
        clear_set      = 1'b0;

        case (state)
            TAG: begin
                rd_way  = hit_way;
                rd_word = req_blkoff;
                if (halt) begin
                    next_state     = HALT;
                    next_flush_idx = '0;
                end else if (req) begin
                    if (hit) begin
                        dhit   = 1'b1;
                        touch  = 1'b1;
                        cpu_we = dmemWEN;
                    end else if (victim_dirty) begin
                        next_state = WB1;
                    end else begin
                        next_state = AL1;
                    end
                end
            end

            // victim writeback, word 0 then word 1
            WB1: begin
                dWEN     = 1'b1;
                addr_tag = victim_tag;
                if (!dwait) begin
                    next_state = WB2;
                end
            end

            WB2: begin
                dWEN      = 1'b1;
                addr_tag  = victim_tag;
                addr_word = 1'b1;
                rd_word   = 1'b1;
                if (!dwait) begin
                    next_state = AL1;
                end
            end

            // refill; the second word marks the line valid
            AL1: begin
                dREN    = 1'b1;
                fill_we = !dwait;
                if (!dwait) begin
                    next_state = AL2;
                end
            end

            AL2: begin
                dREN      = 1'b1;
                addr_word = 1'b1;
                fill_word = 1'b1;
                fill_we   = !dwait;
                if (!dwait) begin
                    next_state = TAG;
                end
            end

            // one set per visit, dirty ways first
            HALT: begin
                if (dirty0 || dirty1) begin
                    next_state = HALTWB1;
                end else begin
                    clear_set = 1'b1;
                    if (flush_idx == idx_t'(SETS - 1)) begin
                        next_state = FLUSHED;
                    end else begin
                        next_flush_idx = flush_idx + 1'b1;
                    end
                end
            end

            HALTWB1: begin
                dWEN     = 1'b1;
                rd_way   = flush_way;
                addr_tag = flush_tag;
                if (!dwait) begin
                    next_state = HALTWB2;
                end
            end

            HALTWB2: begin
                dWEN      = 1'b1;
                rd_way    = flush_way;
                rd_word   = 1'b1;
                addr_tag  = flush_tag;
                addr_word = 1'b1;
                if (!dwait) begin
                    clean_we   = 1'b1;
                    next_state = HALT;
                end
            end

            FLUSHED: begin
                if (!halt) begin
                    next_state = TAG;
                end
            end

            default: begin
                next_state = TAG;
            end
        endcase
    end

endmodule

//--- design/dcache_line_store.sv
`timescale 1ns/100ps

module dcache_line_store
    import dcache_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  idx_t  set_idx,
    input  way_t  rd_way,
    input  logic  rd_word,
    input  logic  fill_we,
    input  way_t  fill_way,
    input  logic  fill_word,
    input  tag_t  fill_tag,
    input  word_t fill_data,
    input  logic  cpu_we,
    input  way_t  cpu_way,
    input  logic  cpu_word,
    input  word_t cpu_data,
    input  logic  touch,
    input  way_t  touch_way,
    input  logic  clean_we,
    input  way_t  clean_way,
    input  logic  clear_set,
    output tag_t  tag0,
    output tag_t  tag1,
    output logic  valid0,
    output logic  valid1,
    output logic  dirty0,
    output logic  dirty1,
    output logic  lru,
    output word_t rd_data
);

    // per set, per way
    logic [1:0]      valid_q [SETS];
    logic [1:0]      dirty_q [SETS];
    tag_t            tag_q   [SETS][2];
    word_t           data_q  [SETS][2][BLK_WORDS];
    logic [SETS-1:0] lru_q;

    // combinational read of the selected set
    assign tag0    = tag_q[set_idx][0];
    assign tag1    = tag_q[set_idx][1];
    assign valid0  = valid_q[set_idx][0];
    assign valid1  = valid_q[set_idx][1];
    assign dirty0  = dirty_q[set_idx][0];
    assign dirty1  = dirty_q[set_idx][1];
    assign lru     = lru_q[set_idx];
    assign rd_data = data_q[set_idx][rd_way][rd_word];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            tag_q   <= '{default: '0};
            data_q  <= '{default: '0};
            lru_q   <= '0;
        end else begin
            // first word drops valid, second word restores it clean
            if (fill_we) begin
                tag_q[set_idx][fill_way]             <= fill_tag;
                data_q[set_idx][fill_way][fill_word] <= fill_data;
                valid_q[set_idx][fill_way]           <= fill_word;
                dirty_q[set_idx][fill_way]           <= 1'b0;
            end

            if (cpu_we) begin
                data_q[set_idx][cpu_way][cpu_word] <= cpu_data;
                dirty_q[set_idx][cpu_way]          <= 1'b1;
            end

            // most recent use makes the other way the victim
            if (touch) begin
                lru_q[set_idx] <= ~touch_way;
            end

            if (clean_we) begin
                dirty_q[set_idx][clean_way] <= 1'b0;
            end

            if (clear_set) begin
                valid_q[set_idx] <= 2'b00;
                dirty_q[set_idx] <= 2'b00;
            end
        end
    end

endmodule

//--- design/dcache.sv
`timescale 1ns/100ps

module dcache
    import dcache_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  halt,
    input  logic  dmemREN,
    input  logic  dmemWEN,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    output logic  dhit,
    output word_t dmemload,
    output logic  flushed,
    output logic  dREN,
    output logic  dWEN,
    output word_t daddr,
    output word_t dstore,
    input  word_t dload,
    input  logic  dwait
);

    // tag match
    idx_t  req_idx;
    logic  req_blkoff;
    logic  hit;
    way_t  hit_way;
    way_t  victim_way;
    logic  victim_dirty;
    tag_t  victim_tag;

    // line store read side
    tag_t  tag0;
    tag_t  tag1;
    logic  valid0;
    logic  valid1;
    logic  dirty0;
    logic  dirty1;
    logic  lru;
    word_t rd_data;

    // controller strobes
    idx_t  set_idx;
    way_t  rd_way;
    logic  rd_word;
    logic  fill_we;
    way_t  fill_way;
    logic  fill_word;
    tag_t  fill_tag;
    logic  cpu_we;
    way_t  cpu_way;
    logic  touch;
    way_t  touch_way;
    logic  clean_we;
    way_t  clean_way;
    logic  clear_set;

    // one read port serves the processor and the writeback
    assign dmemload = rd_data;
    assign dstore   = rd_data;

    dcache_tag_match u_tag_match (
        .req_addr     (dmemaddr),
        .tag0         (tag0),
        .tag1         (tag1),
        .valid0       (valid0),
        .valid1       (valid1),
        .dirty0       (dirty0),
        .dirty1       (dirty1),
        .lru          (lru),
        .req_idx      (req_idx),
        .req_blkoff   (req_blkoff),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_controller u_controller (
        .CLK          (CLK),
        .nRST         (nRST),
        .halt         (halt),
        .dmemREN      (dmemREN),
        .dmemWEN      (dmemWEN),
        .dmemaddr     (dmemaddr),
        .req_idx      (req_idx),
        .req_blkoff   (req_blkoff),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .dirty0       (dirty0),
        .dirty1       (dirty1),
        .tag0         (tag0),
        .tag1         (tag1),
        .dwait        (dwait),
        .dhit         (dhit),
        .flushed      (flushed),
        .dREN         (dREN),
        .dWEN         (dWEN),
        .daddr        (daddr),
        .set_idx      (set_idx),
        .rd_way       (rd_way),
        .rd_word      (rd_word),
        .fill_we      (fill_we),
        .fill_way     (fill_way),
        .fill_word    (fill_word),
        .fill_tag     (fill_tag),
        .cpu_we       (cpu_we),
        .cpu_way      (cpu_way),
        .touch        (touch),
        .touch_way    (touch_way),
        .clean_we     (clean_we),
        .clean_way    (clean_way),
        .clear_set    (clear_set)
    );

    dcache_line_store u_line_store (
        .CLK       (CLK),
        .nRST      (nRST),
        .set_idx   (set_idx),
        .rd_way    (rd_way),
        .rd_word   (rd_word),
        .fill_we   (fill_we),
        .fill_way  (fill_way),
        .fill_word (fill_word),
        .fill_tag  (fill_tag),
        .fill_data (dload),
        .cpu_we    (cpu_we),
        .cpu_way   (cpu_way),
        .cpu_word  (req_blkoff),
        .cpu_data  (dmemstore),
        .touch     (touch),
        .touch_way (touch_way),
        .clean_we  (clean_we),
        .clean_way (clean_way),
        .clear_set (clear_set),
        .tag0      (tag0),
        .tag1      (tag1),
        .valid0    (valid0),
        .valid1    (valid1),
        .dirty0    (dirty0),
        .dirty1    (dirty1),
        .lru       (lru),
        .rd_data   (rd_data)
    );

endmodule

//--- bench/dcache_sva.sv
`timescale 1ns/100ps

module dcache_sva
    import dcache_pkg::*;
(
    input logic        CLK,
    input logic        nRST,
    input logic        halt,
    input logic        flushed,
    input logic        dREN,
    input logic        dWEN,
    input logic        dwait,
    input word_t       daddr
);

    // failed assertion tally
    int fail_count = 0;

    // one memory port carries one direction at a time
    no_dual_request: assert property (
        @(posedge CLK) disable iff (!nRST) !(dREN && dWEN)
    ) else begin
        $error("memory read and write requested together");
        fail_count++;
    end

    word_aligned: assert property (
        @(posedge CLK) disable iff (!nRST) (dREN || dWEN) |-> (daddr[1:0] == 2'b00)
    ) else begin
        $error("memory address not word aligned");
        fail_count++;
    end

    flushed_needs_halt: assert property (
        @(posedge CLK) disable iff (!nRST) flushed |-> halt
    ) else begin
        $error("flushed high without halt");
        fail_count++;
    end

    // a stalled word keeps its request
    stable_under_wait: assert property (
        @(posedge CLK) disable iff (!nRST)
        ((dREN || dWEN) && dwait) |=> ($stable(dREN) && $stable(dWEN) && $stable(daddr))
    ) else begin
        $error("memory request changed while dwait was high");
        fail_count++;
    end

endmodule

//--- bench/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int MEM_WORDS = 256;
    localparam logic [1:0] OP_RD = 2'd0;
    localparam logic [1:0] OP_WR = 2'd1;
    localparam logic [1:0] OP_HALT = 2'd2;

    typedef struct packed {
        logic [1:0] kind;
        word_t      addr;
        word_t      data;
        logic       exp_hit;
    } op_t;

    logic  CLK;
    logic  nRST;
    logic  halt;
    logic  dmemREN;
    logic  dmemWEN;
    word_t dmemaddr;
    word_t dmemstore;
    logic  dhit;
    word_t dmemload;
    logic  flushed;
    logic  dREN;
    logic  dWEN;
    word_t daddr;
    word_t dstore;
    word_t dload;
    logic  dwait;

    word_t       mem [MEM_WORDS];
    word_t       golden [MEM_WORDS];
    op_t         ops [$];
    word_t       rd_addrs [$];
    word_t       wr_addrs [$];
    logic [31:0] lfsr;
    int          wait_left;
    bit          table_ready;

    dcache uut (
        .CLK       (CLK),
        .nRST      (nRST),
        .halt      (halt),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .flushed   (flushed),
        .dREN      (dREN),
        .dWEN      (dWEN),
        .daddr     (daddr),
        .dstore    (dstore),
        .dload     (dload),
        .dwait     (dwait)
    );

    bind dcache dcache_sva sva_checks (
        .CLK     (CLK),
        .nRST    (nRST),
        .halt    (halt),
        .flushed (flushed),
        .dREN    (dREN),
        .dWEN    (dWEN),
        .dwait   (dwait),
        .daddr   (daddr)
    );

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic int word_index(input word_t a);
        return int'(a[9:2]);
    endfunction

    function automatic word_t initial_word(input int i);
        return 32'hc0de_0000 ^ (32'(i) << 2) ^ (32'(i) << 20);
    endfunction

    // galois form with one output bit per step
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_wait(output int cycles);
        logic [1:0] bits;
        bits = 2'b00;
        for (int i = 0; i < 2; i++) begin
            bits = {bits[0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        cycles = int'(bits);
    endtask

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic value_error(input string msg);
        stop_on_error($sformatf("CHECK FAILED at %0t: %s", $time, msg));
    endtask

    task automatic add_op(input logic [1:0] kind, input word_t addr, input word_t data,
                          input logic exp_hit);
        op_t op;
        op.kind = kind;
        op.addr = addr;
        op.data = data;
        op.exp_hit = exp_hit;
        ops.push_back(op);
    endtask

    // set = addr[5:3], word = addr[2], tag = addr[31:6]
    task automatic build_table();
        add_op(OP_RD, 32'h000, 32'h0, 1'b0);
        add_op(OP_RD, 32'h004, 32'h0, 1'b1);
        add_op(OP_WR, 32'h004, 32'hdead_0004, 1'b1);
        add_op(OP_RD, 32'h004, 32'h0, 1'b1);
        add_op(OP_RD, 32'h040, 32'h0, 1'b0);
        // third tag in set 0 evicts the dirty line
        add_op(OP_RD, 32'h080, 32'h0, 1'b0);
        add_op(OP_RD, 32'h004, 32'h0, 1'b0);
        add_op(OP_RD, 32'h044, 32'h0, 1'b0);
        // both ways of set 1 dirty
        add_op(OP_WR, 32'h0c8, 32'h1234_5678, 1'b0);
        add_op(OP_WR, 32'h0cc, 32'h9abc_def0, 1'b1);
        add_op(OP_WR, 32'h10c, 32'h0bad_f00d, 1'b0);
        add_op(OP_RD, 32'h0c8, 32'h0, 1'b1);
        add_op(OP_WR, 32'h3b8, 32'hfeed_3b8f, 1'b0);
        add_op(OP_HALT, 32'h0, 32'h0, 1'b0);
        add_op(OP_RD, 32'h0c8, 32'h0, 1'b0);
        add_op(OP_RD, 32'h004, 32'h0, 1'b0);
        add_op(OP_RD, 32'h3bc, 32'h0, 1'b0);
        add_op(OP_RD, 32'h3b8, 32'h0, 1'b1);
        add_op(OP_WR, 32'h3fc, 32'h5555_aaaa, 1'b0);
        add_op(OP_RD, 32'h3f8, 32'h0, 1'b1);
        add_op(OP_HALT, 32'h0, 32'h0, 1'b0);
        add_op(OP_RD, 32'h3fc, 32'h0, 1'b0);
        add_op(OP_RD, 32'h10c, 32'h0, 1'b0);
    endtask

    // memory port model with random dwait stalls
    initial begin
        lfsr = 32'h4bbf_caef;
        dwait = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = initial_word(i);
            golden[i] = mem[i];
        end
        draw_wait(wait_left);
        forever begin
            @(posedge CLK);
            if (nRST && (dREN || dWEN)) begin
                if (!dwait) begin
                    if (dWEN) begin
                        assert (dstore == golden[word_index(daddr)])
                        else value_error($sformatf("writeback to %h carried %h, expected %h",
                            daddr, dstore, golden[word_index(daddr)]));
                        mem[word_index(daddr)] <= dstore;
                        wr_addrs.push_back(daddr);
                    end else begin
                        rd_addrs.push_back(daddr);
                    end
                    draw_wait(wait_left);
                end else begin
                    wait_left = wait_left - 1;
                end
            end
            #1;
            dwait = (wait_left != 0);
        end
    end

    assign dload = mem[word_index(daddr)];

    task automatic apply_op(input op_t op, input int n);
        int    addr_i;
        word_t base;
        logic  traffic;
        logic  done;
        addr_i = word_index(op.addr);
        base = {op.addr[31:3], 3'b000};
        traffic = 1'b0;
        rd_addrs.delete();
        wr_addrs.delete();
        halt = (op.kind == OP_HALT);
        dmemREN = (op.kind == OP_RD);
        dmemWEN = (op.kind == OP_WR);
        dmemaddr = op.addr;
        dmemstore = op.data;

        // hold the request until the cache answers
        do begin
            @(negedge CLK);
            if (dREN || dWEN) begin
                traffic = 1'b1;
            end
            done = (op.kind == OP_HALT) ? flushed : dhit;
        end while (!done);

        // writebacks come in aligned word pairs
        assert (wr_addrs.size() % 2 == 0)
        else value_error($sformatf("op %0d wrote %0d words", n, wr_addrs.size()));
        for (int k = 0; k + 1 < wr_addrs.size(); k += 2) begin
            assert (wr_addrs[k][2:0] == 3'b000 && wr_addrs[k + 1] == wr_addrs[k] + 4)
            else value_error($sformatf("op %0d writeback pair %h %h", n,
                wr_addrs[k], wr_addrs[k + 1]));
        end

        if (op.kind == OP_HALT) begin
            assert (rd_addrs.size() == 0)
            else value_error($sformatf("op %0d flush read memory", n));
            for (int i = 0; i < MEM_WORDS; i++) begin
                assert (mem[i] == golden[i])
                else value_error($sformatf("after flush word %h holds %h, expected %h",
                    32'(i) << 2, mem[i], golden[i]));
            end
        end else begin
            assert (traffic == !op.exp_hit)
            else value_error($sformatf("op %0d at %h memory traffic %0b, expected %0b",
                n, op.addr, traffic, !op.exp_hit));
            if (traffic) begin
                assert (rd_addrs.size() == 2 && rd_addrs[0] == base && rd_addrs[1] == base + 4)
                else value_error($sformatf("op %0d refill did not read %h and %h",
                    n, base, base + 4));
                assert (wr_addrs.size() <= 2)
                else value_error($sformatf("op %0d wrote back %0d words", n, wr_addrs.size()));
            end
            if (op.kind == OP_RD) begin
                assert (dmemload == golden[addr_i])
                else value_error($sformatf("op %0d read %h returned %h, expected %h",
                    n, op.addr, dmemload, golden[addr_i]));
            end else begin
                golden[addr_i] = op.data;
            end
        end

        @(posedge CLK);
        #1;
        halt = 1'b0;
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
    endtask

    initial begin
        nRST = 1'b0;
        halt = 1'b0;
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
        dmemaddr = '0;
        dmemstore = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;

        foreach (ops[i]) begin
            apply_op(ops[i], i);
        end

        @(posedge CLK);
        if (uut.sva_checks.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "assertion failures during the run");
        end
    end

    // budget of 60 cycles per table entry
    initial begin
        wait (table_ready);
        repeat (ops.size() * 60) @(posedge CLK);
        stop_on_error("timeout: the cache did not finish the operation table in time");
    end

endmodule

//--- verilog.f
design/dcache_pkg.sv
design/dcache_tag_match.sv
design/dcache_controller.sv
design/dcache_line_store.sv
design/dcache.sv
bench/dcache_sva.sv
bench/dcache_tb.sv
